//--- common/dot_params.svh
`ifndef DOT_PARAMS_SVH
`define DOT_PARAMS_SVH

// width of each unsigned operand.
`define OPERAND_W 8

// full product of two operands.
`define PRODUCT_W (2 * `OPERAND_W)

// running sum and result width, clamped at all ones.
`define ACC_W 20

// cycles from a pair taken with en to its product on the output.
`define MUL_LATENCY 4

`endif

//--- common/dot_pkg.sv
`include "dot_params.svh"

package dot_pkg;

  // ****************************************
  // data vectors of the dot-product path
  // ****************************************

  // one unsigned multiplier input.
  typedef logic [`OPERAND_W-1:0] operand_t;

  // an unsigned product, also used for the partial sums of the adder tree.
  typedef logic [`PRODUCT_W-1:0] product_t;

  // the running sum of a vector and the published result.
  typedef logic [`ACC_W-1:0] acc_t;

endpackage

//--- dot_product_top.f
+incdir+common
common/dot_pkg.sv
multiplier/mul_pipe.sv
rtl/dot_accum.sv
rtl/dot_product_top.sv
verification/dot_product_tb.sv

//--- multiplier/mul_pipe.sv
`include "dot_params.svh"

module mul_pipe (
  input  logic              clk,
  input  logic              rst_n,
  input  dot_pkg::operand_t a,
  input  dot_pkg::operand_t b,
  input  logic              en,
  input  logic              last,
  output logic              prod_valid,
  output logic              prod_last,
  output dot_pkg::product_t product
);

  import dot_pkg::*;

  operand_t                 a_q;
  operand_t                 b_q;
  product_t                 pp [`OPERAND_W];
  product_t                 pair_sum [`OPERAND_W/2];
  product_t                 total_q;
  logic [`MUL_LATENCY-2:0]  en_chain;
  logic [`MUL_LATENCY-2:0]  last_chain;

  // ****************************************
  // stage 1: operand register
  // ****************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      a_q <= en ? a : '0;  // idle cycles push zeros through the tree.
      b_q <= en ? b : '0;
    end
  end

  // each set bit of b selects a copy of a shifted to that bit position.
  always_comb begin
    for (int i = 0; i < `OPERAND_W; i++) begin
      pp[i] = b_q[i] ? (product_t'(a_q) << i) : '0;
    end
  end

  // ****************************************
  // stage 2: pairwise partial sums
  // ****************************************

  // the two largest terms stay below 2^16 together, so no carry is lost.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `OPERAND_W/2; i++) begin
        pair_sum[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `OPERAND_W/2; i++) begin
        pair_sum[i] <= pp[2*i] + pp[2*i+1];
      end
    end
  end

  // ****************************************
  // stage 3: final sum
  // ****************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      total_q <= '0;
    end else begin
      total_q <= pair_sum[0] + pair_sum[1] + pair_sum[2] + pair_sum[3];  // at most 65025.
    end
  end

  // ****************************************
  // side pipeline for enable and last
  // ****************************************

  // bit 0 lines up with the operand register, the top bit with the final sum.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_chain   <= '0;
      last_chain <= '0;
    end else begin
      en_chain   <= {en_chain[`MUL_LATENCY-3:0], en};
      last_chain <= {last_chain[`MUL_LATENCY-3:0], en & last};  // last counts only with en.
    end
  end

  // ****************************************
  // stage 4: gated output register
  // ****************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_valid <= 1'b0;
      prod_last  <= 1'b0;
      product    <= '0;
    end else begin
      prod_valid <= en_chain[`MUL_LATENCY-2];
      prod_last  <= last_chain[`MUL_LATENCY-2];
      if (en_chain[`MUL_LATENCY-2]) begin
        product <= total_q;
      end else begin
        product <= '0;  // the accumulator may add product without looking at valid.
      end
    end
  end

  // a vector can only close on a product that is really there.
  a_last_with_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    prod_last |-> prod_valid
  );

  // no stale sum may leak onto the output between valid products.
  a_zero_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    (product != '0) |-> prod_valid
  );

endmodule

//--- rtl/dot_accum.sv
`include "dot_params.svh"

module dot_accum (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              prod_valid,
  input  logic              prod_last,
  input  dot_pkg::product_t product,
  output logic              dot_valid,
  output dot_pkg::acc_t     dot_out,
  output logic              sat
);

  import dot_pkg::*;

  acc_t             acc_q;     // running sum of the open vector.
  logic             sat_q;     // set once the open vector has clamped.
  logic [`ACC_W:0]  sum_ext;   // one spare bit catches the carry out.
  logic             ovf;
  acc_t             sum_sat;
  logic             sat_next;

  // ****************************************
  // saturating add
  // ****************************************

  // product is zero while prod_valid is low, so this sum is always safe.
  assign sum_ext  = {1'b0, acc_q} + {{(`ACC_W - `PRODUCT_W + 1){1'b0}}, product};
  assign ovf      = sum_ext[`ACC_W];
  assign sum_sat  = ovf ? '1 : sum_ext[`ACC_W-1:0];
  assign sat_next = sat_q | ovf;

  // once clamped, the sum stays at all ones since any further term overflows again.

  // ****************************************
  // per-vector state
  // ****************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
      sat_q <= 1'b0;
    end else if (prod_valid) begin
      if (prod_last) begin
        acc_q <= '0;  // the next product opens a fresh vector.
        sat_q <= 1'b0;
      end else begin
        acc_q <= sum_sat;
        sat_q <= sat_next;
      end
    end
  end

  // ****************************************
  // result register
  // ****************************************

  // the result is shown for a single cycle and dot_out reads zero otherwise.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dot_valid <= 1'b0;
      dot_out   <= '0;
      sat       <= 1'b0;
    end else if (prod_valid && prod_last) begin
      dot_valid <= 1'b1;
      dot_out   <= sum_sat;   // includes the closing product.
      sat       <= sat_next;
    end else begin
      dot_valid <= 1'b0;
      dot_out   <= '0;
      sat       <= 1'b0;
    end
  end

  // the clamp flag belongs to a published result only.
  a_sat_with_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    sat |-> dot_valid
  );

endmodule

//--- rtl/dot_product_top.sv
module dot_product_top (
  input  logic              clk,
  input  logic              rst_n,
  input  dot_pkg::operand_t a,
  input  dot_pkg::operand_t b,
  input  logic              en,
  input  logic              last,
  output logic              dot_valid,
  output dot_pkg::acc_t     dot_out,
  output logic              sat
);

  import dot_pkg::*;

  // product stream from the multiplier, one term per cycle at most.
  logic     prod_valid;
  logic     prod_last;
  product_t product;

  // ****************************************
  // four-stage multiplier
  // ****************************************

  mul_pipe mul_pipe_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .a          (a),
    .b          (b),
    .en         (en),
    .last       (last),
    .prod_valid (prod_valid),
    .prod_last  (prod_last),
    .product    (product)
  );

  // ****************************************
  // vector accumulator
  // ****************************************

  // the result follows the closing pair by one more register stage.
  dot_accum dot_accum_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .prod_valid (prod_valid),
    .prod_last  (prod_last),
    .product    (product),
    .dot_valid  (dot_valid),
    .dot_out    (dot_out),
    .sat        (sat)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the dot-product testbench with Verilator and runs it.
# The run counts as failed when the log holds the fail message.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=dot_product_sim
LOG_FILE=sim.log

verilator --binary --assert -j 0 \
  --top-module dot_product_tb \
  -f dot_product_top.f \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG_FILE"; then
  echo "simulation reported failure, see $LOG_FILE"
  exit 1
fi

echo "simulation finished without failure"
exit 0

//--- verification/dot_product_tb.sv
`include "dot_params.svh"

module dot_product_tb;

  import dot_pkg::*;

  localparam int NUM_TESTS    = 10;
  localparam int RESULT_DELAY = `MUL_LATENCY + 1;  // multiplier plus the result register.
  localparam int ACC_MAX      = (1 << `ACC_W) - 1;
  localparam int MODE_RANDOM  = 0;
  localparam int MODE_MAX     = 1;
  localparam int MODE_ZERO    = 2;
  localparam int MODE_FIXED   = 3;

  logic     clk;
  logic     rst_n;
  operand_t a;
  operand_t b;
  logic     en;
  logic     last;
  logic     dot_valid;
  acc_t     dot_out;
  logic     sat;

  integer seed = 32'h97458202;
  int     cycle = 0;
  int     cycle_limit;
  int     errors = 0;
  int     checks = 0;
  int     cur_test = 0;

  acc_t   exp_sum_q [$];
  logic   exp_sat_q [$];
  int     last_cyc_q [$];  // cycle of each closing pair, in order.

  // ****************************************
  // stimulus table
  // ****************************************

  // a term count of zero picks a random length from 2 to 8 for each vector.
  string test_name [NUM_TESTS] = '{"single_0x255", "single_255x0", "single_1x1",
                                   "single_max", "random_b2b", "random_gaps", "all_zero",
                                   "max_16", "max_17_sat", "after_sat"};
  int vec_cnt  [NUM_TESTS] = '{1, 1, 1, 1, 6, 4, 2, 1, 1, 3};
  int term_cnt [NUM_TESTS] = '{1, 1, 1, 1, 0, 5, 4, 16, 17, 3};
  int mode     [NUM_TESTS] = '{MODE_FIXED, MODE_FIXED, MODE_FIXED, MODE_MAX, MODE_RANDOM,
                               MODE_RANDOM, MODE_ZERO, MODE_MAX, MODE_MAX, MODE_RANDOM};
  int fix_a    [NUM_TESTS] = '{0, 255, 1, 0, 0, 0, 0, 0, 0, 0};
  int fix_b    [NUM_TESTS] = '{255, 0, 1, 0, 0, 0, 0, 0, 0, 0};
  int gap      [NUM_TESTS] = '{0, 0, 0, 0, 0, 2, 1, 0, 0, 0};

  dot_product_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .a         (a),
    .b         (b),
    .en        (en),
    .last      (last),
    .dot_valid (dot_valid),
    .dot_out   (dot_out),
    .sat       (sat)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("timeout: no progress after %0d cycles", cycle);
      $display("TEST FAIL");
      $finish;
    end
  end

  // outputs are sampled on the falling edge, half a cycle after they change.
  always @(negedge clk) begin
    if (rst_n) begin
      if (en && last) begin
        last_cyc_q.push_back(cycle);
      end
      if (dot_valid) begin
        check_result();
      end
    end
  end

  function automatic int cycle_budget();
    int total;
    int terms;
    total = 50;
    for (int t = 0; t < NUM_TESTS; t++) begin
      terms = (term_cnt[t] == 0) ? 8 : term_cnt[t];
      total += vec_cnt[t] * terms * (gap[t] + 1) + 10;
    end
    return total;
  endfunction

  // ****************************************
  // checks
  // ****************************************

  task automatic check_result();
    acc_t exp_sum;
    logic exp_sat;
    int   exp_cyc;
    if (exp_sum_q.size() == 0) begin
      $display("%s: a result appeared with no vector pending", test_name[cur_test]);
      errors++;
    end else begin
      exp_sum = exp_sum_q.pop_front();
      exp_sat = exp_sat_q.pop_front();
      exp_cyc = (last_cyc_q.size() != 0) ? last_cyc_q.pop_front() + RESULT_DELAY : -1;
      checks += 3;
      assert (dot_out == exp_sum) else begin
        $display("ERROR %s: dot_out expected %0d, actual %0d", test_name[cur_test],
                 exp_sum, dot_out);
        errors++;
      end
      assert (sat == exp_sat) else begin
        $display("ERROR %s: sat expected %0d, actual %0d", test_name[cur_test], exp_sat, sat);
        errors++;
      end
      assert (cycle == exp_cyc) else begin
        $display("ERROR %s: result cycle expected %0d, actual %0d", test_name[cur_test],
                 exp_cyc, cycle);
        errors++;
      end
    end
  endtask

  task automatic check_reset_state();
    checks += 3;
    assert (dot_valid == 1'b0) else begin
      $display("ERROR reset_state: dot_valid expected 0, actual %0d", dot_valid);
      errors++;
    end
    assert (sat == 1'b0) else begin
      $display("ERROR reset_state: sat expected 0, actual %0d", sat);
      errors++;
    end
    assert (dot_out == '0) else begin
      $display("ERROR reset_state: dot_out expected 0, actual %0d", dot_out);
      errors++;
    end
    $display("%-12s done, %0d errors", "reset_state", errors);
  endtask

  // ****************************************
  // drivers
  // ****************************************

  task automatic drive_term(input operand_t av, input operand_t bv, input logic is_last);
    a    <= av;
    b    <= bv;
    en   <= 1'b1;
    last <= is_last;
    @(posedge clk);
  endtask

  // junk operands and a raised last must not reach the sum while en is low.
  task automatic drive_idle(input int n);
    repeat (n) begin
      a    <= operand_t'($random(seed));
      b    <= operand_t'($random(seed));
      en   <= 1'b0;
      last <= 1'b1;
      @(posedge clk);
    end
  endtask

  initial begin : stimulus
    int       terms;
    int       ref_sum;
    int       errors_before;
    int       checks_before;
    operand_t av;
    operand_t bv;
    cycle_limit = cycle_budget();
    a     <= '0;
    b     <= '0;
    en    <= 1'b0;
    last  <= 1'b0;
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_reset_state();
    @(posedge clk);
    for (int t = 0; t < NUM_TESTS; t++) begin
      cur_test      = t;
      errors_before = errors;
      checks_before = checks;
      for (int v = 0; v < vec_cnt[t]; v++) begin
        terms   = (term_cnt[t] == 0) ? 2 + ($unsigned($random(seed)) % 7) : term_cnt[t];
        ref_sum = 0;
        for (int i = 0; i < terms; i++) begin
          case (mode[t])
            MODE_RANDOM: begin
              av = operand_t'($random(seed));
              bv = operand_t'($random(seed));
            end
            MODE_MAX: begin
              av = 8'hff;
              bv = 8'hff;
            end
            MODE_ZERO: begin
              av = '0;
              bv = '0;
            end
            default: begin
              av = operand_t'(fix_a[t]);
              bv = operand_t'(fix_b[t]);
            end
          endcase
          ref_sum += int'(av) * int'(bv);
          if (i == terms - 1) begin  // the sum clamps at all ones of the result width.
            exp_sum_q.push_back((ref_sum > ACC_MAX) ? acc_t'(ACC_MAX) : acc_t'(ref_sum));
            exp_sat_q.push_back(ref_sum > ACC_MAX);
          end
          drive_term(av, bv, i == terms - 1);
          drive_idle(gap[t]);
        end
      end
      en   <= 1'b0;
      last <= 1'b0;
      while (exp_sum_q.size() != 0) @(posedge clk);
      $display("%-12s done, %0d vectors, %0d checks, %0d errors", test_name[t], vec_cnt[t],
               checks - checks_before, errors - errors_before);
    end
    if (last_cyc_q.size() != 0 || exp_sum_q.size() != 0) begin
      $display("%0d closing pairs are still waiting for a result", last_cyc_q.size());
      errors++;
    end
    $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS + 1, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
